//--- vlog.f
+incdir+include
logic/radio_ctrl_pkg.sv
logic/clock_ready_reset.sv
logic/apb_setting_decode.sv
logic/fe_atr_channel.sv
logic/readback_mux.sv
logic/radio_ctrl_top.sv
verification/radio_ctrl_assert.sv
verification/radio_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the radio control regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module radio_ctrl_tb -o radio_ctrl_sim

# A stopped simulation counts as a failure too
status=0
./obj_dir/radio_ctrl_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Regression failed" sim.log; then
   echo "Simulation failed, see sim.log"
   exit 1
fi
echo "Simulation finished clean"

//--- verification/radio_ctrl_tb.sv
/* Directed testbench for the radio front-end control block
   Drives APB transfers, run states and lock, and checks results against a word model */
`timescale 1ns/1ps
`include "radio_ctrl_params.svh"

module radio_ctrl_tb
   import radio_ctrl_pkg::*;
();

   localparam int CLK_NS   = 4;
   localparam int NUM_TEST = 6;
   localparam int RESET_NS = (4 + 4 + `HOLDOFF_CYCLES + 2) * CLK_NS;  // Reset and lock wait
   localparam int LIMIT_NS = RESET_NS + NUM_TEST * 200;

   logic                      bus_clk;
   logic                      reset_global;
   logic                      locked;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   logic [7:0]                paddr;
   bus_word_t                 pwdata;
   bus_word_t                 prdata;
   logic                      pready;
   logic                      pslverr;
   logic [`NUM_CHAN-1:0]      run_rx;
   logic [`NUM_CHAN-1:0]      run_tx;
   atr_word_t [`NUM_CHAN-1:0] fe_pins;
   logic                      bus_rst;

   int        errors;
   int        checks;
   atr_word_t model [`NUM_CHAN][4];   // Expected ATR words per channel and index

   radio_ctrl_top UUT (
      .bus_clk(bus_clk), .reset_global(reset_global), .locked(locked),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
      .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .run_rx(run_rx), .run_tx(run_tx), .fe_pins(fe_pins), .bus_rst(bus_rst)
   );

   initial begin
      bus_clk = 1'b0;
      forever #(CLK_NS / 2) bus_clk = ~bus_clk;
   end

   // Watchdog
   initial begin
      #(LIMIT_NS);
      $display("Watchdog expired at %0d ns before the tests finished", LIMIT_NS);
      $display("Regression failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [7:0] reg_addr(input int ch, input int idx);
      return 8'((ch << `CHAN_LSB) | (idx << `REG_LSB));
   endfunction

   task automatic check_val(input string name, input bus_word_t got, input bus_word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error: %s got %h expected %h", name, got, exp);
      end
   endtask

   // One APB transfer that returns on the negedge after pready
   task automatic bus_transfer(input logic wr, input int ch, input int idx,
                               input bus_word_t wdata,
                               output bus_word_t rdata, output logic err);
      int waits;
      @(negedge bus_clk);
      psel    = 1'b1;                 // Setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = reg_addr(ch, idx);
      pwdata  = wdata;
      @(negedge bus_clk);
      penable = 1'b1;                 // Access phase
      waits   = 0;
      while (!pready && waits < 8) begin
         waits++;
         @(negedge bus_clk);
      end
      checks++;
      if (!pready) begin
         errors++;
         $display("No pready within 8 cycles for channel %0d word %0d", ch, idx);
      end else if (waits != 1) begin
         errors++;
         $display("Transfer to channel %0d word %0d took %0d wait states", ch, idx, waits);
      end
      rdata = prdata;
      err   = pslverr;
      @(negedge bus_clk);             // Master ends the transfer after pready edge
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input int ch, input int idx, input bus_word_t data,
                            input logic exp_err);
      bus_word_t rd;
      logic      err;
      bus_transfer(1'b1, ch, idx, data, rd, err);
      check_val($sformatf("pslverr write ch %0d idx %0d", ch, idx),
                bus_word_t'(err), bus_word_t'(exp_err));
   endtask

   task automatic apb_read(input int ch, input int idx, output bus_word_t data,
                           output logic err);
      bus_transfer(1'b0, ch, idx, $urandom, data, err);   // pwdata must not matter
   endtask

   // Every mapped word against the model
   task automatic read_all();
      bus_word_t rd;
      logic      err;
      for (int ch = 0; ch < `NUM_CHAN; ch++) begin
         for (int idx = 0; idx < 4; idx++) begin
            apb_read(ch, idx, rd, err);
            check_val($sformatf("prdata ch %0d idx %0d", ch, idx), rd,
                      bus_word_t'(model[ch][idx]));
            check_val($sformatf("pslverr read ch %0d idx %0d", ch, idx),
                      bus_word_t'(err), '0);
         end
      end
   endtask

   // Counts edges until bus_rst is low while pins stay clear
   task automatic wait_release(output int edges);
      edges = 0;
      while (bus_rst && edges < 4 * `HOLDOFF_CYCLES) begin
         @(posedge bus_clk);
         edges++;
         @(negedge bus_clk);
         if (bus_rst) check_val("fe_pins during reset", bus_word_t'(fe_pins), '0);
      end
      if (bus_rst) begin
         checks++;
         errors++;
         $display("bus_rst still high %0d cycles after lock", edges);
      end
   endtask

   task automatic set_run(input int ch, input reg_idx_t st);
      @(negedge bus_clk);
      run_tx[ch] = st[1];
      run_rx[ch] = st[0];
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////////////
   task automatic reset_release();
      int edges;
      repeat (4) @(negedge bus_clk);
      reset_global = 1'b0;
      repeat (4) begin                // Not locked yet
         @(negedge bus_clk);
         check_val("bus_rst before lock", bus_word_t'(bus_rst), 32'h1);
         check_val("fe_pins before lock", bus_word_t'(fe_pins), '0);
      end
      locked = 1'b1;
      wait_release(edges);
      check_val("bus_rst release edge", bus_word_t'(edges), bus_word_t'(`HOLDOFF_CYCLES + 2));
   endtask

   task automatic register_access();
      bus_word_t data;
      for (int ch = 0; ch < `NUM_CHAN; ch++) begin
         for (int idx = 0; idx < 4; idx++) begin
            data = $urandom;
            apb_write(ch, idx, data, 1'b0);
            model[ch][idx] = data[7:0];   // Upper bytes dropped
         end
      end
      read_all();
   endtask

   task automatic atr_selection();
      atr_word_t [`NUM_CHAN-1:0] snap;
      for (int ch = 0; ch < `NUM_CHAN; ch++) begin
         for (int st = 0; st < 4; st++) begin
            snap = fe_pins;
            set_run(ch, reg_idx_t'(st));
            @(negedge bus_clk);          // One cycle after the change
            check_val($sformatf("fe_pins ch %0d state %0d", ch, st),
                      bus_word_t'(fe_pins[ch]), bus_word_t'(model[ch][st]));
            for (int o = 0; o < `NUM_CHAN; o++) begin
               if (o != ch) begin
                  check_val($sformatf("fe_pins ch %0d untouched", o),
                            bus_word_t'(fe_pins[o]), bus_word_t'(snap[o]));
               end
            end
         end
      end
   endtask

   task automatic live_rewrite();
      reg_idx_t  st;
      bus_word_t data;
      set_run(0, 2'd1);                // Rx on channel 0 while the others stay full duplex
      for (int ch = 0; ch < `NUM_CHAN; ch++) begin
         st   = {run_tx[ch], run_rx[ch]};
         data = $urandom;
         apb_write(ch, int'(st), data, 1'b0);  // Returns one cycle after pready
         model[ch][st] = data[7:0];
         check_val($sformatf("fe_pins ch %0d after rewrite", ch),
                   bus_word_t'(fe_pins[ch]), bus_word_t'(model[ch][st]));
      end
   endtask

   task automatic unmapped_access();
      bus_word_t rd;
      logic      err;
      apb_write(`NUM_CHAN, 1, $urandom, 1'b1);
      apb_read(`NUM_CHAN, 2, rd, err);
      check_val("prdata unmapped", rd, '0);
      check_val("pslverr unmapped read", bus_word_t'(err), 32'h1);
      read_all();                       // Nothing real was touched
   endtask

   task automatic lock_loss();
      int edges;
      @(negedge bus_clk);
      locked = 1'b0;
      #1;                               // Async path needs no clock edge
      check_val("bus_rst on lock loss", bus_word_t'(bus_rst), 32'h1);
      check_val("fe_pins on lock loss", bus_word_t'(fe_pins), '0);
      repeat (3) begin
         @(negedge bus_clk);
         check_val("bus_rst while unlocked", bus_word_t'(bus_rst), 32'h1);
      end
      locked = 1'b1;
      wait_release(edges);
      check_val("bus_rst relock edge", bus_word_t'(edges), bus_word_t'(`HOLDOFF_CYCLES + 2));
      for (int ch = 0; ch < `NUM_CHAN; ch++) begin
         for (int idx = 0; idx < 4; idx++) model[ch][idx] = '0;
      end
      read_all();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      reset_global = 1'b1;
      locked       = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      run_rx       = '0;
      run_tx       = '0;
      errors       = 0;
      checks       = 0;
      void'($urandom(32'h471a_c983));
      for (int ch = 0; ch < `NUM_CHAN; ch++) begin
         for (int idx = 0; idx < 4; idx++) model[ch][idx] = '0;
      end

      $display("Test 1 reset release");
      reset_release();
      $display("Test 2 register access");
      register_access();
      $display("Test 3 ATR selection");
      atr_selection();
      $display("Test 4 live rewrite");
      live_rewrite();
      $display("Test 5 unmapped channel");
      unmapped_access();
      $display("Test 6 lock loss");
      lock_loss();

      $display("Checks run %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- verification/radio_ctrl_assert.sv
/* APB handshake and reset checks, bound onto the radio control top level */
`timescale 1ns/1ps
`include "radio_ctrl_params.svh"

module radio_ctrl_assert
   import radio_ctrl_pkg::*;
(
   input logic                      bus_clk,
   input logic                      locked,
   input logic                      psel,
   input logic                      penable,
   input logic                      pready,
   input logic                      pslverr,
   input logic                      bus_rst,
   input atr_word_t [`NUM_CHAN-1:0] fe_pins
);

   // Response only inside an access phase
   a_pready_access: assert property (@(posedge bus_clk) pready |-> (psel && penable))
      else $error("pready high outside an access phase");

   a_pslverr_ready: assert property (@(posedge bus_clk) pslverr |-> pready)
      else $error("pslverr high without pready");

   // Switches and tx enable off in reset
   a_pins_reset: assert property (@(posedge bus_clk) bus_rst |-> (fe_pins == '0))
      else $error("fe_pins not clear while bus_rst is high");

   a_unlock_reset: assert property (@(posedge bus_clk) !locked |-> bus_rst)
      else $error("bus_rst low while the clock is unlocked");

endmodule

bind radio_ctrl_top radio_ctrl_assert u_assert (
   .bus_clk(bus_clk), .locked(locked), .psel(psel), .penable(penable),
   .pready(pready), .pslverr(pslverr), .bus_rst(bus_rst), .fe_pins(fe_pins)
);

//--- logic/radio_ctrl_top.sv
/* Radio front-end control block of the SDR board
   Reset release, APB settings port and one ATR channel per radio path */
`timescale 1ns/1ps
`include "radio_ctrl_params.svh"

module radio_ctrl_top
   import radio_ctrl_pkg::*;
(
   input  logic                      bus_clk,
   input  logic                      reset_global,
   input  logic                      locked,       // Clock manager lock
   // APB slave
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [7:0]                paddr,
   input  bus_word_t                 pwdata,
   output bus_word_t                 prdata,
   output logic                      pready,
   output logic                      pslverr,
   // Radio paths
   input  logic [`NUM_CHAN-1:0]      run_rx,
   input  logic [`NUM_CHAN-1:0]      run_tx,
   output atr_word_t [`NUM_CHAN-1:0] fe_pins,
   output logic                      bus_rst       // Ready low for software
);

   bus_req_t                  req;
   atr_word_t [`NUM_CHAN-1:0] chan_rd;

   ////////////////////////////////////////////////////////////////////////////
   // Reset and bus front end
   ////////////////////////////////////////////////////////////////////////////
   clock_ready_reset u_reset (
      .bus_clk(bus_clk), .reset_global(reset_global), .locked(locked), .bus_rst(bus_rst)
   );

   apb_setting_decode u_decode (
      .bus_clk(bus_clk), .bus_rst(bus_rst),
      .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .req(req)
   );

   ////////////////////////////////////////////////////////////////////////////
   // ATR channels and readback
   ////////////////////////////////////////////////////////////////////////////
   for (genvar i = 0; i < `NUM_CHAN; i++) begin : g_chan
      fe_atr_channel #(.CHAN_ID(i)) u_chan (
         .bus_clk(bus_clk), .bus_rst(bus_rst), .req(req),
         .run_rx(run_rx[i]), .run_tx(run_tx[i]),
         .rd_data(chan_rd[i]), .atr_pins(fe_pins[i])
      );
   end

   readback_mux u_readback (
      .bus_clk(bus_clk), .bus_rst(bus_rst), .req(req), .chan_rd(chan_rd),
      .prdata(prdata), .pready(pready), .pslverr(pslverr)
   );

endmodule

//--- logic/readback_mux.sv
/* APB response stage for the ATR settings
   Picks the addressed channel's word and returns it with pready after one wait state */
`timescale 1ns/1ps
`include "radio_ctrl_params.svh"

module readback_mux
   import radio_ctrl_pkg::*;
(
   input  logic                          bus_clk,
   input  logic                          bus_rst,
   input  bus_req_t                      req,
   input  atr_word_t [`NUM_CHAN-1:0]     chan_rd,
   output bus_word_t                     prdata,
   output logic                          pready,
   output logic                          pslverr
);

   atr_word_t rd_sel;

   // Addressed channel, zero when the channel is unmapped
   always_comb begin
      rd_sel = '0;
      if (!req.err) begin
         for (int i = 0; i < `NUM_CHAN; i++) begin
            if (req.chan == chan_idx_t'(i)) rd_sel = chan_rd[i];
         end
      end
   end

   // Handshake, one cycle wide
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         pready  <= 1'b0;
         pslverr <= 1'b0;
      end else begin
         pready  <= req.valid;
         pslverr <= req.valid & req.err;   // Only ever with pready
      end
   end

   // Read data, byte zero-extended to bus width
   always_ff @(posedge bus_clk) begin
      if (req.valid) prdata <= bus_word_t'(rd_sel);
   end

endmodule

//--- logic/fe_atr_channel.sv
/* One radio path's ATR settings and front-end pin register
   Holds the idle, rx, tx and full-duplex words and drives the word for the run state */
`timescale 1ns/1ps

module fe_atr_channel
   import radio_ctrl_pkg::*;
#(
   parameter int CHAN_ID = 0
) (
   input  logic      bus_clk,
   input  logic      bus_rst,
   input  bus_req_t  req,
   input  logic      run_rx,
   input  logic      run_tx,
   output atr_word_t rd_data,
   output atr_word_t atr_pins
);

   atr_word_t atr_words [4];   // Indexed by reg_idx_t
   logic      wr_hit;
   reg_idx_t  run_state;

   // Write hit for this path, err never set here since chan is mapped
   assign wr_hit = req.valid & req.write & (req.chan == chan_idx_t'(CHAN_ID));

   // Same encoding as the word index, tx high and rx low
   assign run_state = {run_tx, run_rx};

   ////////////////////////////////////////////////////////////////////////////
   // Settings words
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         for (int i = 0; i < 4; i++) begin
            atr_words[i] <= '0;                 // All words read 0 after reset
         end
      end else if (wr_hit) begin
         atr_words[req.idx] <= req.wdata;       // Lands at end of first access cycle
      end
   end

   assign rd_data = atr_words[req.idx];         // Readback stage qualifies by chan

   ////////////////////////////////////////////////////////////////////////////
   // Pin register
   ////////////////////////////////////////////////////////////////////////////
   // Follows run state or a rewritten word one cycle later
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) atr_pins <= '0;              // Switches, LEDs, tx enable off
      else         atr_pins <= atr_words[run_state];
   end

endmodule

//--- logic/apb_setting_decode.sv
/* APB slave front end for the ATR settings
   Turns each setup phase into one registered request for the channels and readback */
`timescale 1ns/1ps
`include "radio_ctrl_params.svh"

module apb_setting_decode
   import radio_ctrl_pkg::*;
(
   input  logic      bus_clk,
   input  logic      bus_rst,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  logic [7:0] paddr,
   input  bus_word_t pwdata,
   output bus_req_t  req
);

   logic      setup_phase;
   chan_idx_t chan_d;
   reg_idx_t  idx_d;

   logic      valid_q;
   logic      write_q;
   logic      err_q;
   chan_idx_t chan_q;
   reg_idx_t  idx_q;
   atr_word_t wdata_q;

   ////////////////////////////////////////////////////////////////////////////
   // Address split
   ////////////////////////////////////////////////////////////////////////////
   assign setup_phase = psel & ~penable;                     // First cycle of a transfer
   assign chan_d      = paddr[`CHAN_LSB +: $bits(chan_idx_t)];
   assign idx_d       = paddr[`REG_LSB  +: $bits(reg_idx_t)];

   // Request strobe, exactly one cycle per transfer
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) valid_q <= 1'b0;
      else         valid_q <= setup_phase;
   end

   // Request fields, only looked at with valid
   always_ff @(posedge bus_clk) begin
      if (setup_phase) begin
         write_q <= pwrite;
         err_q   <= (chan_d >= chan_idx_t'(`NUM_CHAN));     // Unmapped path
         chan_q  <= chan_d;
         idx_q   <= idx_d;
         wdata_q <= pwdata[$bits(atr_word_t)-1:0];          // Upper bytes ignored
      end
   end

   assign req = '{valid: valid_q,
                  write: write_q,
                  err:   err_q,
                  chan:  chan_q,
                  idx:   idx_q,
                  wdata: wdata_q};

endmodule

//--- logic/clock_ready_reset.sv
/* Clock-ready hold-off and bus reset release
   Keeps bus_rst high until the clock is locked and the hold-off count has run out */
`timescale 1ns/1ps
`include "radio_ctrl_params.svh"

module clock_ready_reset (
   input  logic bus_clk,
   input  logic reset_global,
   input  logic locked,
   output logic bus_rst
);

   localparam int CNT_W = $clog2(`HOLDOFF_CYCLES) + 1;

   logic             arst;           // Board reset or clock manager unlocked
   logic [CNT_W-1:0] holdoff_cnt;
   logic             clocks_ready;
   logic [1:0]       rst_sync;       // [1] is the output stage

   assign arst = reset_global | ~locked;

   // Hold-off counter, stops once ready
   always_ff @(posedge bus_clk or posedge arst) begin
      if (arst) begin
         holdoff_cnt  <= '0;
         clocks_ready <= 1'b0;
      end else if (!clocks_ready) begin
         holdoff_cnt  <= holdoff_cnt + 1'b1;
         clocks_ready <= (holdoff_cnt == CNT_W'(`HOLDOFF_CYCLES - 1)); // Flag on edge N
      end
   end

   // Two-stage sync, async assert and clocked release
   always_ff @(posedge bus_clk or posedge arst) begin
      if (arst) rst_sync <= 2'b11;
      else      rst_sync <= {rst_sync[0], ~clocks_ready};
   end

   assign bus_rst = rst_sync[1];   // Falls HOLDOFF_CYCLES+2 edges after release

endmodule

//--- logic/radio_ctrl_pkg.sv
/* Shared types for the radio front-end control block
   Imported by the bus decoder, the ATR channels, the readback stage and the top */
package radio_ctrl_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Vector types
   ////////////////////////////////////////////////////////////////////////////

   // One radio path's pin word, MSB first:
   // tx_enable, fdx_rx, fdx_tx, srx_rx, srx_tx, led_rx, led_txrx_rx, led_txrx_tx
   typedef logic [7:0]  atr_word_t;

   typedef logic [3:0]  chan_idx_t;   // Channel field of paddr
   typedef logic [1:0]  reg_idx_t;    // 0 idle, 1 rx, 2 tx, 3 full duplex
   typedef logic [31:0] bus_word_t;   // APB data width

   ////////////////////////////////////////////////////////////////////////////
   // Registered bus request, one cycle per APB setup phase
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic      valid;   // High for the first access cycle only
      logic      write;
      logic      err;     // Channel beyond the mapped paths
      chan_idx_t chan;
      reg_idx_t  idx;
      atr_word_t wdata;   // Low byte of pwdata
   } bus_req_t;

endpackage

//--- include/radio_ctrl_params.svh
/* Build-time sizes and APB address layout of the radio control block
   Included by every module that needs the channel count or field positions */
`ifndef RADIO_CTRL_PARAMS_SVH
`define RADIO_CTRL_PARAMS_SVH

// Number of radio paths, sizes run inputs and pin outputs
`define NUM_CHAN 2

// Bus clocks after lock before the reset synchronizer is released
`define HOLDOFF_CYCLES 16

// paddr layout
`define CHAN_LSB 4   // Channel in bits 7..4
`define REG_LSB  2   // ATR word index in bits 3..2

`endif
